// File: Makefile
# Verilator build and run of the fc layer accelerator testbench

VERILATOR ?= verilator
TOP       ?= tb_fc_accel
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+1000

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f list.f

run: compile
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) 2>&1 | tee $(LOG)
	@grep -q "^TB PASSED$$" $(LOG) || (echo "pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: list.f
logic/fc_pkg.sv
logic/mac_pe.sv
logic/stream_loader.sv
logic/shared_buffer.sv
logic/fc_engine.sv
logic/result_packer.sv
logic/fc_accel.sv
test/fc_accel_assertions.sv
test/tb_fc_accel.sv

// File: logic/fc_accel.sv
// top level of the fully connected layer accelerator
// loads features, biases and weights over the input stream, then a run
// command streams out one packed word of four results per output group
`timescale 1ns/1ns

module fc_accel (
  input  logic                          clk,
  input  logic                          rstn,
  input  logic                          s_tvalid,
  output logic                          s_tready,
  input  logic [fc_pkg::data_w-1:0]     s_tdata,
  output logic                          m_tvalid,
  input  logic                          m_tready,
  output logic [fc_pkg::data_w-1:0]     m_tdata,
  output logic                          m_tlast,
  input  fc_pkg::fc_cmd_e               command,
  input  logic                          start,
  input  logic [fc_pkg::addr_w-1:0]     size,
  output logic                          load_done,
  output logic                          fc_done
);

  logic                      wr_req;
  logic [fc_pkg::addr_w-1:0] wr_addr;
  logic [fc_pkg::data_w-1:0] wr_data;
  logic                      rd_req;
  logic [fc_pkg::addr_w-1:0] rd_addr;
  logic                      rd_grant;
  logic [fc_pkg::data_w-1:0] rd_data;
  logic [fc_pkg::addr_w-1:0] feat_words;
  logic [fc_pkg::addr_w-1:0] bias_words;

  // engine to packer
  logic                      acc_valid;
  logic [fc_pkg::acc_w-1:0]  acc0;
  logic [fc_pkg::acc_w-1:0]  acc1;
  logic [fc_pkg::acc_w-1:0]  acc2;
  logic [fc_pkg::acc_w-1:0]  acc3;
  logic [fc_pkg::data_w-1:0] bias_word;
  logic                      m_last;
  logic                      pack_ready;

  stream_loader u_loader (
    .clk(clk), .rstn(rstn), .command(command), .start(start), .size(size),
    .s_tvalid(s_tvalid), .s_tdata(s_tdata), .s_tready(s_tready),
    .wr_req(wr_req), .wr_addr(wr_addr), .wr_data(wr_data),
    .feat_words(feat_words), .bias_words(bias_words), .load_done(load_done)
  );

  shared_buffer u_buffer (
    .clk(clk), .wr_req(wr_req), .wr_addr(wr_addr), .wr_data(wr_data),
    .rd_req(rd_req), .rd_addr(rd_addr), .rd_grant(rd_grant), .rd_data(rd_data)
  );

  fc_engine u_engine (
    .clk(clk), .rstn(rstn), .command(command), .start(start),
    .feat_words(feat_words), .bias_words(bias_words),
    .rd_grant(rd_grant), .rd_data(rd_data), .pack_ready(pack_ready),
    .rd_req(rd_req), .rd_addr(rd_addr), .acc_valid(acc_valid),
    .acc0(acc0), .acc1(acc1), .acc2(acc2), .acc3(acc3),
    .bias_word(bias_word), .m_last(m_last), .fc_done(fc_done)
  );

  result_packer u_packer (
    .clk(clk), .rstn(rstn), .acc_valid(acc_valid),
    .acc0(acc0), .acc1(acc1), .acc2(acc2), .acc3(acc3),
    .bias_word(bias_word), .m_last(m_last), .m_tready(m_tready),
    .pack_ready(pack_ready), .m_tvalid(m_tvalid), .m_tdata(m_tdata), .m_tlast(m_tlast)
  );

endmodule

// File: logic/fc_engine.sv
// run sequencer of the accelerator
// walks the outputs four at a time: bias word, then per feature word the
// feature and four weight words, fed byte by byte into four mac elements,
// and hands the four sums to the packer once the pipeline has drained
`timescale 1ns/1ns

module fc_engine (
  input  logic                      clk,
  input  logic                      rstn,
  input  fc_pkg::fc_cmd_e           command,
  input  logic                      start,
  input  logic [fc_pkg::addr_w-1:0] feat_words,
  input  logic [fc_pkg::addr_w-1:0] bias_words,
  input  logic                      rd_grant,
  input  logic [fc_pkg::data_w-1:0] rd_data,
  input  logic                      pack_ready,
  output logic                      rd_req,
  output logic [fc_pkg::addr_w-1:0] rd_addr,
  output logic                      acc_valid,
  output logic [fc_pkg::acc_w-1:0]  acc0,
  output logic [fc_pkg::acc_w-1:0]  acc1,
  output logic [fc_pkg::acc_w-1:0]  acc2,
  output logic [fc_pkg::acc_w-1:0]  acc3,
  output logic [fc_pkg::data_w-1:0] bias_word,
  output logic                      m_last,
  output logic                      fc_done
);

  fc_pkg::engine_state_e       state;
  logic [fc_pkg::addr_w-1:0]   grp;       // output group
  logic [fc_pkg::addr_w-1:0]   kw;        // feature word
  logic [2:0]                  iss;       // reads issued in this fetch
  logic [2:0]                  step;      // feed byte, then drain count
  logic [2:0]                  slot;
  logic [2:0]                  rd_sel;    // where the returning word goes
  logic                        rd_pend;
  logic [1:0]                  lane_sel;
  logic [fc_pkg::addr_w-1:0]   out_idx;
  logic [2*fc_pkg::addr_w-1:0] row_off;
  logic                        last_grp;
  logic                        last_word;
  logic [fc_pkg::data_w-1:0]   feat_reg;
  logic [fc_pkg::data_w-1:0]   wt_reg [fc_pkg::lanes];
  logic                        pe_en;
  logic                        pe_first;
  logic [fc_pkg::byte_w-1:0]   pe_a;
  logic [fc_pkg::byte_w-1:0]   pe_b [fc_pkg::lanes];
  logic [fc_pkg::acc_w-1:0]    acc_lane [fc_pkg::lanes];

  ////////////////////////////////////////////////////////////
  // buffer addressing

  assign lane_sel  = iss[1:0] - 2'd1;  // reads 1..4 are weight rows 0..3
  assign out_idx   = {grp[fc_pkg::addr_w-3:0], lane_sel};
  assign row_off   = out_idx * feat_words;
  assign slot      = (state == fc_pkg::st_bias) ? 3'd5 : iss;
  assign last_grp  = (grp == bias_words - 1'b1);
  assign last_word = (kw == feat_words - 1'b1);

  assign rd_req  = ((state == fc_pkg::st_bias) && (iss == 3'd0)) ||
                   ((state == fc_pkg::st_fetch) && (iss < 3'd5));
  assign rd_addr = (state == fc_pkg::st_bias) ? fc_pkg::bias_base + grp :
                   (iss == 3'd0) ? fc_pkg::feat_base + kw :
                   fc_pkg::weight_base + row_off[fc_pkg::addr_w-1:0] + kw;

  // operands for the macs
  assign pe_en    = (state == fc_pkg::st_feed);
  assign pe_first = pe_en && (kw == '0) && (step == 3'd0);
  assign pe_a     = feat_reg[fc_pkg::byte_w*step[1:0] +: fc_pkg::byte_w];

  genvar j;
  generate
    for (j = 0; j < fc_pkg::lanes; j++) begin : g_lane
      assign pe_b[j] = wt_reg[j][fc_pkg::byte_w*step[1:0] +: fc_pkg::byte_w];
      mac_pe u_pe (
        .clk(clk), .rstn(rstn), .en(pe_en), .first(pe_first),
        .a(pe_a), .b(pe_b[j]), .acc(acc_lane[j])
      );
    end
  endgenerate

  assign acc0      = acc_lane[0];
  assign acc1      = acc_lane[1];
  assign acc2      = acc_lane[2];
  assign acc3      = acc_lane[3];
  assign acc_valid = (state == fc_pkg::st_hand) && pack_ready;
  assign m_last    = last_grp;

  ////////////////////////////////////////////////////////////
  // sequencer FSM

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state   <= fc_pkg::st_idle;
      rd_pend <= 1'b0;
      fc_done <= 1'b0;
    end else begin
      fc_done <= 1'b0;
      rd_pend <= rd_req & rd_grant;
      if (rd_req && rd_grant) iss <= iss + 3'd1;  // ungranted reads repeat
      case (state)
        fc_pkg::st_idle: begin
          if (start && command == fc_pkg::cmd_run) begin
            grp   <= '0;
            kw    <= '0;
            iss   <= '0;
            state <= fc_pkg::st_bias;
          end
        end
        fc_pkg::st_bias: begin
          if (rd_pend) begin
            iss   <= '0;
            state <= fc_pkg::st_fetch;
          end
        end
        fc_pkg::st_fetch: begin
          if (rd_pend && rd_sel == 3'd4) begin
            step  <= '0;
            state <= fc_pkg::st_feed;
          end
        end
        fc_pkg::st_feed: begin
          step <= step + 3'd1;
          if (step == 3'd3) begin
            step <= '0;
            if (last_word) begin
              state <= fc_pkg::st_drain;
            end else begin
              kw    <= kw + 1'b1;
              iss   <= '0;
              state <= fc_pkg::st_fetch;
            end
          end
        end
        fc_pkg::st_drain: begin
          step <= step + 3'd1;
          if (step == 3'(fc_pkg::pe_latency - 2)) state <= fc_pkg::st_hand;
        end
        fc_pkg::st_hand: begin
          if (pack_ready) begin
            if (last_grp) begin
              state <= fc_pkg::st_flush;
            end else begin
              grp   <= grp + 1'b1;
              kw    <= '0;
              iss   <= '0;
              state <= fc_pkg::st_bias;
            end
          end
        end
        fc_pkg::st_flush: begin
          if (pack_ready) begin  // last word handshakes this cycle
            fc_done <= 1'b1;
            state   <= fc_pkg::st_idle;
          end
        end
        default: state <= fc_pkg::st_idle;
      endcase
    end
  end

  // read return capture
  always_ff @(posedge clk) begin
    rd_sel <= slot;
    if (rd_pend) begin
      case (rd_sel)
        3'd0:    feat_reg <= rd_data;
        3'd5:    bias_word <= rd_data;
        default: wt_reg[rd_sel[1:0] - 2'd1] <= rd_data;
      endcase
    end
  end

endmodule

// File: logic/fc_pkg.sv
// shared widths, buffer map and encodings for the fc layer accelerator
// every rtl file reaches these through fc_pkg:: scoped names
package fc_pkg;

  localparam int data_w      = 32;  // stream and buffer word
  localparam int byte_w      = 8;   // operand width
  localparam int acc_w       = 28;
  localparam int addr_w      = 10;
  localparam int buf_depth   = 1024;
  localparam int lanes       = 4;   // mac elements per group, bytes per word
  localparam int pe_latency  = 5;   // en to updated accumulator
  localparam int quant_shift = 6;   // low bits dropped in requantize

  // word bases of the three buffer regions
  localparam logic [addr_w-1:0] feat_base   = 10'd0;
  localparam logic [addr_w-1:0] bias_base   = 10'd256;
  localparam logic [addr_w-1:0] weight_base = 10'd512;

  localparam logic [byte_w-1:0] quant_max = 8'd127;

  typedef enum logic [1:0] {
    cmd_load_feat,
    cmd_load_bias,
    cmd_load_weight,
    cmd_run
  } fc_cmd_e;

  typedef enum logic [2:0] {
    st_idle,
    st_bias,   // fetch the group's bias word
    st_fetch,  // feature word plus four weight words
    st_feed,   // one byte per cycle into the macs
    st_drain,  // wait for the mac pipeline
    st_hand,   // pass sums to the packer
    st_flush   // last word still in the output register
  } engine_state_e;

endpackage

// File: logic/mac_pe.sv
// pipelined signed 8x8 multiply accumulate element
// a valid pair enters on en; five stages later the product is added to
// acc, or loaded into it when first came with the pair
`timescale 1ns/1ns

module mac_pe (
  input  logic                      clk,
  input  logic                      rstn,
  input  logic                      en,
  input  logic                      first,
  input  logic [fc_pkg::byte_w-1:0] a,
  input  logic [fc_pkg::byte_w-1:0] b,
  output logic [fc_pkg::acc_w-1:0]  acc
);

  logic [3:0]  vld_q;     // one bit per stage boundary
  logic [3:0]  first_q;
  logic [2:0]  sign_q;
  logic [7:0]  a_mag;
  logic [7:0]  b_mag;
  logic [7:0]  pp [8];    // partial products
  logic [9:0]  pair [4];
  logic [15:0] prod_mag;
  logic [15:0] prod;      // signed product

  assign prod_mag = {6'd0, pair[0]} + {4'd0, pair[1], 2'd0} +
                    {2'd0, pair[2], 4'd0} + {pair[3], 6'd0};

  always_ff @(posedge clk) begin
    if (!rstn) begin
      vld_q <= '0;
    end else begin
      vld_q <= {vld_q[2:0], en};
    end
  end

  ////////////////////////////////////////////////////////////
  // stages 1 to 4, free running, validity rides in vld_q

  always_ff @(posedge clk) begin
    sign_q  <= {sign_q[1:0], a[7] ^ b[7]};
    first_q <= {first_q[2:0], first};
    a_mag   <= a[7] ? (~a + 1'b1) : a;  // -128 gives 8'h80
    b_mag   <= b[7] ? (~b + 1'b1) : b;
    for (int i = 0; i < 8; i++) begin
      pp[i] <= b_mag[i] ? a_mag : 8'd0;
    end
    for (int k = 0; k < 4; k++) begin
      pair[k] <= {2'd0, pp[2*k]} + {1'b0, pp[2*k+1], 1'b0};
    end
    prod <= sign_q[2] ? (~prod_mag + 1'b1) : prod_mag;
  end

  // stage 5 accumulate
  always_ff @(posedge clk) begin
    if (vld_q[3]) begin
      acc <= (first_q[3] ? '0 : acc) + {{(fc_pkg::acc_w-16){prod[15]}}, prod};
    end
  end

endmodule

// File: logic/result_packer.sv
// output stage: bias add, relu, saturating requantize to 7 bits and
// packing of the four lanes into one output stream word
// the word sits in the output register until the sink takes it
`timescale 1ns/1ns

module result_packer (
  input  logic                      clk,
  input  logic                      rstn,
  input  logic                      acc_valid,
  input  logic [fc_pkg::acc_w-1:0]  acc0,
  input  logic [fc_pkg::acc_w-1:0]  acc1,
  input  logic [fc_pkg::acc_w-1:0]  acc2,
  input  logic [fc_pkg::acc_w-1:0]  acc3,
  input  logic [fc_pkg::data_w-1:0] bias_word,
  input  logic                      m_last,
  input  logic                      m_tready,
  output logic                      pack_ready,
  output logic                      m_tvalid,
  output logic [fc_pkg::data_w-1:0] m_tdata,
  output logic                      m_tlast
);

  logic [fc_pkg::acc_w-1:0]  acc_lane [fc_pkg::lanes];
  logic [fc_pkg::acc_w-1:0]  sum [fc_pkg::lanes];
  logic [fc_pkg::data_w-1:0] res_word;

  // negative -> 0, too large -> quant_max, else bits 12:6
  function automatic logic [fc_pkg::byte_w-1:0] requant(input logic [fc_pkg::acc_w-1:0] s);
    if (s[fc_pkg::acc_w-1]) return '0;
    if (|s[fc_pkg::acc_w-2:fc_pkg::quant_shift+7]) return fc_pkg::quant_max;
    return {1'b0, s[fc_pkg::quant_shift+6:fc_pkg::quant_shift]};
  endfunction

  assign acc_lane[0] = acc0;
  assign acc_lane[1] = acc1;
  assign acc_lane[2] = acc2;
  assign acc_lane[3] = acc3;

  genvar j;
  generate
    for (j = 0; j < fc_pkg::lanes; j++) begin : g_lane
      assign sum[j] = acc_lane[j] +
        {{(fc_pkg::acc_w-fc_pkg::byte_w){bias_word[fc_pkg::byte_w*j+fc_pkg::byte_w-1]}},
         bias_word[fc_pkg::byte_w*j +: fc_pkg::byte_w]};
      assign res_word[fc_pkg::byte_w*j +: fc_pkg::byte_w] = requant(sum[j]);
    end
  endgenerate

  assign pack_ready = ~m_tvalid | m_tready;  // empty or draining now

  always_ff @(posedge clk) begin
    if (!rstn) begin
      m_tvalid <= 1'b0;
      m_tlast  <= 1'b0;
    end else if (acc_valid) begin
      m_tvalid <= 1'b1;
      m_tlast  <= m_last;
      m_tdata  <= res_word;
    end else if (m_tready) begin
      m_tvalid <= 1'b0;
      m_tlast  <= 1'b0;
    end
  end

endmodule

// File: logic/shared_buffer.sv
// single port on-chip buffer shared by the loader and the engine
// loader writes take the port first, an engine read is granted only
// in a cycle without a write and its data shows up one cycle later
`timescale 1ns/1ns

module shared_buffer (
  input  logic                      clk,
  input  logic                      wr_req,
  input  logic [fc_pkg::addr_w-1:0] wr_addr,
  input  logic [fc_pkg::data_w-1:0] wr_data,
  input  logic                      rd_req,
  input  logic [fc_pkg::addr_w-1:0] rd_addr,
  output logic                      rd_grant,
  output logic [fc_pkg::data_w-1:0] rd_data
);

  logic [fc_pkg::data_w-1:0] mem [fc_pkg::buf_depth];
  logic [fc_pkg::addr_w-1:0] port_addr;

  ////////////////////////////////////////////////////////////
  // fixed priority arbiter

  assign rd_grant  = rd_req & ~wr_req;
  assign port_addr = wr_req ? wr_addr : rd_addr;  // one address for the port

  ////////////////////////////////////////////////////////////
  // memory port

  always_ff @(posedge clk) begin
    if (wr_req) begin
      mem[port_addr] <= wr_data;
    end else if (rd_grant) begin
      rd_data <= mem[port_addr];  // holds until the next granted read
    end
  end

endmodule

// File: logic/stream_loader.sv
// input stream loader
// a load command opens one buffer region and takes size words from the
// stream, each written straight into the buffer as it is accepted
`timescale 1ns/1ns

module stream_loader (
  input  logic                      clk,
  input  logic                      rstn,
  input  fc_pkg::fc_cmd_e           command,
  input  logic                      start,
  input  logic [fc_pkg::addr_w-1:0] size,
  input  logic                      s_tvalid,
  input  logic [fc_pkg::data_w-1:0] s_tdata,
  output logic                      s_tready,
  output logic                      wr_req,
  output logic [fc_pkg::addr_w-1:0] wr_addr,
  output logic [fc_pkg::data_w-1:0] wr_data,
  output logic [fc_pkg::addr_w-1:0] feat_words,
  output logic [fc_pkg::addr_w-1:0] bias_words,
  output logic                      load_done
);

  logic [fc_pkg::addr_w-1:0] base;      // region base of the current load
  logic [fc_pkg::addr_w-1:0] count;
  logic [fc_pkg::addr_w-1:0] last_idx;
  logic                      is_load;

  assign is_load = (command != fc_pkg::cmd_run);
  assign wr_req  = s_tvalid & s_tready;  // loader always wins the port
  assign wr_addr = base + count;
  assign wr_data = s_tdata;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      s_tready   <= 1'b0;
      load_done  <= 1'b0;
      count      <= '0;
      feat_words <= '0;
      bias_words <= '0;
    end else begin
      load_done <= 1'b0;
      if (!s_tready && start && is_load) begin
        s_tready <= 1'b1;
        count    <= '0;
        last_idx <= size - 1'b1;
        case (command)
          fc_pkg::cmd_load_feat: begin
            base       <= fc_pkg::feat_base;
            feat_words <= size;
          end
          fc_pkg::cmd_load_bias: begin
            base       <= fc_pkg::bias_base;
            bias_words <= size;
          end
          default: base <= fc_pkg::weight_base;  // bias_words*4*feat_words long
        endcase
      end else if (wr_req) begin
        count <= count + 1'b1;
        if (count == last_idx) begin
          s_tready  <= 1'b0;
          load_done <= 1'b1;
        end
      end
    end
  end

endmodule

// File: test/fc_accel_assertions.sv
// stream and done protocol checks on the accelerator top level
// bound into fc_accel from the testbench, each failure bumps fails
`timescale 1ns/1ns

module fc_accel_assertions (
  input logic                      clk,
  input logic                      rstn,
  input logic                      s_tready,
  input logic                      start,
  input logic                      load_done,
  input logic                      m_tvalid,
  input logic                      m_tready,
  input logic [fc_pkg::data_w-1:0] m_tdata,
  input logic                      m_tlast,
  input logic                      fc_done
);

  int fails = 0;  // failed checks so far

  ////////////////////////////////////////////////////////////
  // reset and input stream

  a_reset_quiet: assert property (@(posedge clk)
    !rstn |=> !s_tready && !m_tvalid && !m_tlast && !load_done && !fc_done)
    else begin $error("outputs not cleared by reset"); fails++; end

  a_ready_needs_start: assert property (@(posedge clk) disable iff (!rstn)
    !s_tready && !start |=> !s_tready)
    else begin $error("s_tready rose without a load start"); fails++; end

  a_ready_off_at_done: assert property (@(posedge clk) load_done |-> !s_tready)
    else begin $error("s_tready high with load_done"); fails++; end

  a_load_done_pulse: assert property (@(posedge clk) disable iff (!rstn)
    load_done |=> !load_done)
    else begin $error("load_done longer than one cycle"); fails++; end

  ////////////////////////////////////////////////////////////
  // output stream and run end

  a_out_hold: assert property (@(posedge clk) disable iff (!rstn)
    m_tvalid && !m_tready |=> m_tvalid && $stable(m_tdata) && $stable(m_tlast))
    else begin $error("output word changed under back-pressure"); fails++; end

  a_last_needs_valid: assert property (@(posedge clk) m_tlast |-> m_tvalid)
    else begin $error("m_tlast without m_tvalid"); fails++; end

  a_done_after_last: assert property (@(posedge clk) disable iff (!rstn)
    fc_done |-> $past(m_tvalid && m_tready && m_tlast))
    else begin $error("fc_done not right after the last word"); fails++; end

  a_done_pulse: assert property (@(posedge clk) disable iff (!rstn) fc_done |=> !fc_done)
    else begin $error("fc_done longer than one cycle"); fails++; end

endmodule

// File: test/tb_fc_accel.sv
// testbench for the fc layer accelerator
// loads random features, biases and weights over the input stream, runs
// the layer under random output back-pressure and checks every result
// word against a model of the dot product, bias and requantize rule
// protocol checks sit in the bound assertion module
`timescale 1ns/1ns

module tb_fc_accel;

  localparam int feat_n     = 16;                     // feature words
  localparam int bias_n     = 2;                      // one bias word per group
  localparam int out_n      = bias_n * fc_pkg::lanes;
  localparam int weight_n   = out_n * feat_n;
  localparam int max_cycles = 20000;  // ~180 load beats plus a run of a few hundred cycles

  logic                      clk;
  logic                      rstn;
  logic                      s_tvalid;
  logic                      s_tready;
  logic [fc_pkg::data_w-1:0] s_tdata;
  logic                      m_tvalid;
  logic                      m_tready;
  logic [fc_pkg::data_w-1:0] m_tdata;
  logic                      m_tlast;
  fc_pkg::fc_cmd_e           command;
  logic                      start;
  logic [fc_pkg::addr_w-1:0] size;
  logic                      load_done;
  logic                      fc_done;

  logic [fc_pkg::data_w-1:0] feat [feat_n];
  logic [fc_pkg::data_w-1:0] bias [bias_n];
  logic [fc_pkg::data_w-1:0] weight [weight_n];  // output o, word k at o*feat_n+k
  logic [fc_pkg::data_w-1:0] expect_word [bias_n];

  integer seed        = 77;
  int     errors      = 0;
  int     cycles      = 0;
  int     load_pulses = 0;
  int     done_pulses = 0;
  int     words_out   = 0;

  fc_accel dut (
    .clk(clk), .rstn(rstn), .s_tvalid(s_tvalid), .s_tready(s_tready), .s_tdata(s_tdata),
    .m_tvalid(m_tvalid), .m_tready(m_tready), .m_tdata(m_tdata), .m_tlast(m_tlast),
    .command(command), .start(start), .size(size), .load_done(load_done), .fc_done(fc_done)
  );

  bind fc_accel fc_accel_assertions u_assert (
    .clk(clk), .rstn(rstn), .s_tready(s_tready), .start(start), .load_done(load_done),
    .m_tvalid(m_tvalid), .m_tready(m_tready), .m_tdata(m_tdata), .m_tlast(m_tlast),
    .fc_done(fc_done)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // done pulses are registered, so the falling edge sees them settled
  always @(negedge clk) begin
    if (load_done) load_pulses++;
    if (fc_done) done_pulses++;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles == max_cycles) begin
      $display("run did not finish within %0d cycles", max_cycles);
      $display("TB FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // reference model

  function automatic int neuron_sum(input int o);
    int s;
    s = $signed(bias[o / fc_pkg::lanes][8*(o % fc_pkg::lanes) +: 8]);
    for (int k = 0; k < feat_n; k++) begin
      for (int j = 0; j < fc_pkg::lanes; j++) begin
        s += $signed(feat[k][8*j +: 8]) * $signed(weight[o*feat_n + k][8*j +: 8]);
      end
    end
    return s;
  endfunction

  // relu, then 7 bits taken above the dropped fraction, clipped at the top
  function automatic logic [7:0] requantize(input int s);
    if (s < 0) return 8'd0;
    if (s >= (1 << (fc_pkg::quant_shift + 7))) return 8'd127;
    return 8'(s >> fc_pkg::quant_shift);
  endfunction

  task automatic make_data();
    logic [7:0] fb;
    logic [7:0] wb;
    for (int k = 0; k < feat_n; k++) feat[k] = $random(seed);
    for (int b = 0; b < bias_n; b++) bias[b] = $random(seed);
    for (int o = 0; o < out_n; o++) begin
      for (int k = 0; k < feat_n; k++) begin
        for (int j = 0; j < fc_pkg::lanes; j++) begin
          fb = feat[k][8*j +: 8];
          case (o % 3)
            0:       wb = fb;                      // squares, runs into saturation
            1:       wb = 8'd0 - fb;               // negative sum, relu to zero
            default: wb = 8'($random(seed) % 8);   // small weights, mid range
          endcase
          weight[o*feat_n + k][8*j +: 8] = wb;
        end
      end
    end
    for (int g = 0; g < bias_n; g++) begin
      for (int j = 0; j < fc_pkg::lanes; j++) begin
        expect_word[g][8*j +: 8] = requantize(neuron_sum(g*fc_pkg::lanes + j));
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // stimulus

  function automatic logic [fc_pkg::data_w-1:0] region_word(input fc_pkg::fc_cmd_e cmd,
                                                            input int idx);
    case (cmd)
      fc_pkg::cmd_load_feat: return feat[idx];
      fc_pkg::cmd_load_bias: return bias[idx];
      default:               return weight[idx];
    endcase
  endfunction

  task automatic load_region(input fc_pkg::fc_cmd_e cmd, input int n);
    int sent;
    int pulses_before;
    sent = 0;
    pulses_before = load_pulses;
    @(negedge clk);
    command = cmd;
    size    = n[fc_pkg::addr_w-1:0];
    start   = 1'b1;
    @(negedge clk);
    start = 1'b0;
    while (sent < n) begin
      s_tvalid = ($random(seed) % 4) != 0;  // gaps in the stream
      s_tdata  = region_word(cmd, sent);
      if (s_tvalid && s_tready) sent++;     // ready is stable until the next edge
      @(negedge clk);
    end
    // keep offering words, none may be taken
    repeat (3) begin
      s_tvalid = 1'b1;
      s_tdata  = $random(seed);
      if (s_tready) begin
        $display("loader still ready after %0d words at %0t", n, $time);
        errors++;
      end
      @(negedge clk);
    end
    s_tvalid = 1'b0;
    if (load_pulses != pulses_before + 1) begin
      $display("load of %0d words gave %0d load_done pulses", n, load_pulses - pulses_before);
      errors++;
    end
  endtask

  task automatic check_word();
    if (words_out >= bias_n) begin
      $display("extra result word %h at %0t", m_tdata, $time);
      errors++;
    end else begin
      if (m_tdata !== expect_word[words_out]) begin
        $display("error %0t: word %0d is %h, expected %h", $time, words_out, m_tdata,
                 expect_word[words_out]);
        errors++;
      end
      if (m_tlast !== (words_out == bias_n - 1)) begin
        $display("error %0t: word %0d last flag %0b", $time, words_out, m_tlast);
        errors++;
      end
    end
    words_out++;
  endtask

  task automatic run_layer();
    int stalled;  // words already held back for a cycle
    stalled = 0;
    @(negedge clk);
    command = fc_pkg::cmd_run;
    start   = 1'b1;
    @(negedge clk);
    start = 1'b0;
    while (!fc_done) begin
      m_tready = ($random(seed) % 3) != 0;
      if (m_tvalid && stalled == words_out) begin
        m_tready = 1'b0;  // every word sees back-pressure once
        stalled++;
      end
      if (m_tvalid && m_tready) check_word();  // handshake on the coming edge
      @(negedge clk);
    end
    m_tready = 1'b1;
    repeat (8) begin
      @(negedge clk);
      if (m_tvalid) check_word();
    end
    if (words_out != bias_n || done_pulses != 1) begin
      $display("run gave %0d words and %0d fc_done pulses", words_out, done_pulses);
      errors++;
    end
  endtask

  initial begin
    rstn     = 1'b0;
    s_tvalid = 1'b0;
    s_tdata  = '0;
    m_tready = 1'b0;
    command  = fc_pkg::cmd_load_feat;
    start    = 1'b0;
    size     = '0;
    make_data();
    repeat (3) @(negedge clk);
    rstn = 1'b1;
    load_region(fc_pkg::cmd_load_feat, feat_n);
    load_region(fc_pkg::cmd_load_bias, bias_n);
    load_region(fc_pkg::cmd_load_weight, weight_n);
    run_layer();
    $display("data errors %0d, assertion failures %0d, result words %0d",
             errors, dut.u_assert.fails, words_out);
    if (errors == 0 && dut.u_assert.fails == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule
